//--- source/user_io_params.svh
`ifndef USER_IO_PARAMS_SVH
`define USER_IO_PARAMS_SVH

// build-wide constants of the host-control SPI slave

// core-type byte returned as the first byte of every transfer
// the host firmware uses it to pick the protocol variant
`define UIO_CORE_TYPE 8'ha6

// number of joystick words that are stored and driven to the core
// one register per joystick opcode, starting at CMD_JOY0
`define UIO_JOY_COUNT 2

// width of the per-transfer byte counters
// both counters saturate at all ones, so long transfers are harmless
// 10 bits covers the longest transfer the host firmware issues
`define UIO_BYTE_CNT_W 10

`endif

//--- source/spi_proto_pkg.sv
`default_nettype none

package spi_proto_pkg;

    // command byte sent by the host as byte 0 of a transfer
    // values are fixed by the host firmware
    typedef enum logic [7:0] {
        // buttons, switches and video options
        CMD_CONFIG    = 8'h01,
        // host reads a keyboard byte from the core
        CMD_KBD_READ  = 8'h04,
        // host sends a keyboard byte to the core
        CMD_KBD_WRITE = 8'h05,
        // joystick 0, four bytes little endian
        CMD_JOY0      = 8'h60,
        // joystick 1, same layout
        CMD_JOY1      = 8'h61
    } opcode_e;

    // one byte as assembled on the SPI side
    // first_in_transfer marks the opcode byte
    typedef struct packed {
        logic       first_in_transfer;
        logic [7:0] data;
    } rx_byte_t;

    // upper nibble of the keyboard status byte
    // low bit of the status carries the available flag
    localparam logic [3:0] KBD_STATUS_TAG = 4'ha;

endpackage

`default_nettype wire

//--- source/host_if_pkg.sv
`default_nettype none

package host_if_pkg;

    // settings byte written by CMD_CONFIG
    // first member sits at the msb
    typedef struct packed {
        logic [1:0] spare;
        logic       ypbpr;
        logic       scandoubler_disable;
        logic [1:0] switches;
        logic [1:0] buttons;
    } host_config_t;

    // joystick word, lane 0 holds the primary buttons
    typedef logic [3:0][7:0] joy_state_t;

    // keyboard byte pending for the host to read
    typedef struct packed {
        logic       available;
        logic [7:0] data;
    } kbd_tx_t;

    // four-phase req/ack handshake state
    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,
        HS_REQ  = 2'd1,
        HS_DONE = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire

//--- source/spi_frame_shifter.sv
`default_nettype none

`include "user_io_params.svh"

module spi_frame_shifter (
    input  wire logic                   SPI_CLK,
    input  wire logic                   SPI_SS_IO,
    input  wire logic                   mosi,
    output logic                        miso,
    input  wire host_if_pkg::kbd_tx_t   kbd_tx,
    output spi_proto_pkg::rx_byte_t     rx_byte,
    output logic                        rx_toggle,
    output logic                        xfer_active
);

    // bit position inside the current byte
    logic [2:0]                 bit_cnt;
    // byte index inside the transfer, saturating
    logic [`UIO_BYTE_CNT_W-1:0] byte_cnt;
    // first seven bits of the byte being received
    logic [6:0]                 sbuf;
    // opcode of the current transfer
    spi_proto_pkg::opcode_e     opcode_q;
    // flips once per received byte, starts low
    logic                       rx_toggle_q = 1'b0;
    // keyboard value seen at the last byte boundary
    host_if_pkg::kbd_tx_t       kbd_snap;
    // keyboard value used for the byte being shifted out
    host_if_pkg::kbd_tx_t       kbd_view;
    // response byte for the current byte slot
    logic [7:0]                 tx_byte;
    // last bit of a byte is on MOSI now
    logic                       byte_done;

    assign byte_done = &bit_cnt;
    assign rx_toggle = rx_toggle_q;

    // counters and opcode, cleared while SS is high
    always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            bit_cnt     <= 3'd0;
            byte_cnt    <= '0;
            opcode_q    <= spi_proto_pkg::opcode_e'(8'h00);
            xfer_active <= 1'b0;
        end else begin
            // high from the first clock of the transfer
            xfer_active <= 1'b1;
            bit_cnt     <= bit_cnt + 3'd1;
            if (byte_done) begin
                // stop at all ones
                if (~&byte_cnt) begin
                    byte_cnt <= byte_cnt + `UIO_BYTE_CNT_W'(1);
                end
                // byte 0 completes on the 8th rising edge
                if (byte_cnt == '0) begin
                    opcode_q <= spi_proto_pkg::opcode_e'({sbuf, mosi});
                end
            end
        end
    end

    // receive shift register and byte handoff
    // rx_byte is held for the following eight clocks
    always_ff @(posedge SPI_CLK) begin
        if (byte_done) begin
            rx_byte.data              <= {sbuf, mosi};
            rx_byte.first_in_transfer <= (byte_cnt == '0);
            rx_toggle_q               <= ~rx_toggle_q;
        end else begin
            // msb first
            sbuf <= {sbuf[5:0], mosi};
        end
    end

    // capture the keyboard value once per byte slot
    // status and data bits of one byte then come from one value
    always_ff @(negedge SPI_CLK) begin
        if (bit_cnt == 3'd0) begin
            kbd_snap <= kbd_tx;
        end
    end

    // bit 7 of a slot goes out on the boundary edge itself
    assign kbd_view = (bit_cnt == 3'd0) ? kbd_tx : kbd_snap;

    // response byte selection
    always_comb begin
        if (byte_cnt == '0) begin
            // every transfer starts with the core type
            tx_byte = `UIO_CORE_TYPE;
        end else if (opcode_q == spi_proto_pkg::CMD_KBD_READ) begin
            if (byte_cnt == `UIO_BYTE_CNT_W'(1)) begin
                // status byte, tag plus available flag
                tx_byte = {spi_proto_pkg::KBD_STATUS_TAG, 3'b000, kbd_view.available};
            end else begin
                tx_byte = kbd_view.data;
            end
        end else begin
            tx_byte = 8'h00;
        end
    end

    // MISO changes on the falling edge, released while SS is high
    always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            miso <= 1'bz;
        end else begin
            // bit_cnt 0 selects bit 7
            miso <= tx_byte[3'd7 - bit_cnt];
        end
    end

endmodule

`default_nettype wire

//--- source/spi_byte_sync.sv
`default_nettype none

module spi_byte_sync (
    input  wire logic                       clk_sys,
    input  wire spi_proto_pkg::rx_byte_t    rx_byte,
    input  wire logic                       rx_toggle,
    input  wire logic                       xfer_active,
    output logic                            byte_valid,
    output spi_proto_pkg::rx_byte_t         sys_byte,
    output logic                            xfer_end
);

    // toggle through two sync stages plus one for edge detect
    logic [2:0] tog_q;
    // transfer-active flag with the same structure
    logic [2:0] act_q;

    always_ff @(posedge clk_sys) begin
        tog_q <= {tog_q[1:0], rx_toggle};
        act_q <= {act_q[1:0], xfer_active};
        // new toggle is moving into stage 1
        // rx_byte has been stable for a full cycle by now
        if (tog_q[0] ^ tog_q[1]) begin
            sys_byte <= rx_byte;
        end
    end

    // one cycle per toggle change
    assign byte_valid = tog_q[1] ^ tog_q[2];

    // falling edge of the synchronised active flag
    assign xfer_end = act_q[2] & ~act_q[1];

endmodule

`default_nettype wire

//--- source/user_io_decoder.sv
`default_nettype none

`include "user_io_params.svh"

module user_io_decoder (
    input  wire logic                       clk_sys,
    input  wire logic                       byte_valid,
    input  wire spi_proto_pkg::rx_byte_t    sys_byte,
    input  wire logic                       xfer_end,
    output host_if_pkg::host_config_t       host_config,
    output host_if_pkg::joy_state_t         joy0,
    output host_if_pkg::joy_state_t         joy1,
    output logic                            kbd_in_req,
    output logic [7:0]                      kbd_in_data,
    input  wire logic                       kbd_in_ack,
    input  wire logic                       kbd_out_req,
    input  wire logic [7:0]                 kbd_out_data,
    output logic                            kbd_out_ack,
    output host_if_pkg::kbd_tx_t            kbd_tx
);

    // opcode of the transfer in progress
    spi_proto_pkg::opcode_e     cmd_q;
    // byte index, 1 is the first payload byte, saturating
    logic [`UIO_BYTE_CNT_W-1:0] idx_q;
    // joystick storage, one word per joystick opcode
    host_if_pkg::joy_state_t    joy_q [`UIO_JOY_COUNT];
    // keyboard byte taken from the core
    logic [7:0]                 kbd_out_q;
    // handshake states, idle from power up
    host_if_pkg::hs_state_e     in_state  = host_if_pkg::HS_IDLE;
    host_if_pkg::hs_state_e     out_state = host_if_pkg::HS_IDLE;

    logic       payload_valid;
    logic       first_payload;
    logic       joy_hit;
    logic       joy_sel;
    logic [1:0] joy_lane;
    logic       kbd_wr_hit;
    logic       kbd_rd_hit;

    // byte decode
    assign payload_valid = byte_valid && !sys_byte.first_in_transfer;
    assign first_payload = payload_valid && (idx_q == `UIO_BYTE_CNT_W'(1));
    assign kbd_wr_hit    = first_payload && (cmd_q == spi_proto_pkg::CMD_KBD_WRITE);
    assign kbd_rd_hit    = first_payload && (cmd_q == spi_proto_pkg::CMD_KBD_READ);

    // joystick payload bytes 1 to 4 only
    assign joy_hit  = payload_valid
                   && ((cmd_q == spi_proto_pkg::CMD_JOY0)
                    || (cmd_q == spi_proto_pkg::CMD_JOY1))
                   && (idx_q >= `UIO_BYTE_CNT_W'(1))
                   && (idx_q <= `UIO_BYTE_CNT_W'(4));
    assign joy_sel  = (cmd_q == spi_proto_pkg::CMD_JOY1);
    // index 1..4 maps to lane 0..3
    assign joy_lane = idx_q[1:0] - 2'd1;

    // opcode tracking and register writes
    always_ff @(posedge clk_sys) begin
        if (byte_valid) begin
            if (sys_byte.first_in_transfer) begin
                cmd_q <= spi_proto_pkg::opcode_e'(sys_byte.data);
                idx_q <= `UIO_BYTE_CNT_W'(1);
            end else if (~&idx_q) begin
                idx_q <= idx_q + `UIO_BYTE_CNT_W'(1);
            end
        end
        if (first_payload && (cmd_q == spi_proto_pkg::CMD_CONFIG)) begin
            host_config <= host_if_pkg::host_config_t'(sys_byte.data);
        end
        if (joy_hit) begin
            joy_q[joy_sel][joy_lane] <= sys_byte.data;
        end
        // end of transfer wins over a byte in the same cycle
        if (xfer_end) begin
            idx_q <= '0;
        end
    end

    assign joy0 = joy_q[0];
    assign joy1 = joy_q[1];

    // keyboard byte toward the core
    // a write while busy is dropped
    always_ff @(posedge clk_sys) begin
        case (in_state)
            host_if_pkg::HS_IDLE: begin
                if (kbd_wr_hit) begin
                    kbd_in_data <= sys_byte.data;
                    in_state    <= host_if_pkg::HS_REQ;
                end
            end
            host_if_pkg::HS_REQ: begin
                // core took the byte, drop req
                if (kbd_in_ack) begin
                    in_state <= host_if_pkg::HS_DONE;
                end
            end
            host_if_pkg::HS_DONE: begin
                // wait for ack to fall
                if (!kbd_in_ack) begin
                    in_state <= host_if_pkg::HS_IDLE;
                end
            end
            default: in_state <= host_if_pkg::HS_IDLE;
        endcase
    end

    assign kbd_in_req = (in_state == host_if_pkg::HS_REQ);

    // keyboard byte from the core
    // pending from capture until the host reads the status byte
    always_ff @(posedge clk_sys) begin
        case (out_state)
            host_if_pkg::HS_IDLE: begin
                if (kbd_out_req) begin
                    kbd_out_q <= kbd_out_data;
                    out_state <= host_if_pkg::HS_REQ;
                end
            end
            host_if_pkg::HS_REQ: begin
                // host has seen the status byte
                if (kbd_rd_hit) begin
                    out_state <= host_if_pkg::HS_DONE;
                end
            end
            host_if_pkg::HS_DONE: begin
                // ack held until the core drops req
                if (!kbd_out_req) begin
                    out_state <= host_if_pkg::HS_IDLE;
                end
            end
            default: out_state <= host_if_pkg::HS_IDLE;
        endcase
    end

    assign kbd_out_ack = (out_state == host_if_pkg::HS_DONE);

    // value read by the SPI side, static while available is set
    assign kbd_tx.available = (out_state == host_if_pkg::HS_REQ);
    assign kbd_tx.data      = kbd_out_q;

endmodule

`default_nettype wire

//--- source/user_io_top.sv
`default_nettype none

module user_io_top (
    input  wire logic                   SPI_CLK,
    input  wire logic                   SPI_SS_IO,
    input  wire logic                   SPI_MOSI,
    output logic                        SPI_MISO,
    input  wire logic                   clk_sys,
    output host_if_pkg::host_config_t   host_config,
    output host_if_pkg::joy_state_t     joy0,
    output host_if_pkg::joy_state_t     joy1,
    output logic                        kbd_in_req,
    output logic [7:0]                  kbd_in_data,
    input  wire logic                   kbd_in_ack,
    input  wire logic                   kbd_out_req,
    input  wire logic [7:0]             kbd_out_data,
    output logic                        kbd_out_ack
);

    // SPI_CLK side
    spi_proto_pkg::rx_byte_t rx_byte;
    logic                    rx_toggle;
    logic                    xfer_active;
    // clk_sys side
    spi_proto_pkg::rx_byte_t sys_byte;
    logic                    byte_valid;
    logic                    xfer_end;
    // quasi-static, read back across the crossing
    host_if_pkg::kbd_tx_t    kbd_tx;

    spi_frame_shifter u_shifter (
        .SPI_CLK     (SPI_CLK),
        .SPI_SS_IO   (SPI_SS_IO),
        .mosi        (SPI_MOSI),
        .miso        (SPI_MISO),
        .kbd_tx      (kbd_tx),
        .rx_byte     (rx_byte),
        .rx_toggle   (rx_toggle),
        .xfer_active (xfer_active)
    );

    spi_byte_sync u_sync (
        .clk_sys     (clk_sys),
        .rx_byte     (rx_byte),
        .rx_toggle   (rx_toggle),
        .xfer_active (xfer_active),
        .byte_valid  (byte_valid),
        .sys_byte    (sys_byte),
        .xfer_end    (xfer_end)
    );

    user_io_decoder u_decoder (
        .clk_sys      (clk_sys),
        .byte_valid   (byte_valid),
        .sys_byte     (sys_byte),
        .xfer_end     (xfer_end),
        .host_config  (host_config),
        .joy0         (joy0),
        .joy1         (joy1),
        .kbd_in_req   (kbd_in_req),
        .kbd_in_data  (kbd_in_data),
        .kbd_in_ack   (kbd_in_ack),
        .kbd_out_req  (kbd_out_req),
        .kbd_out_data (kbd_out_data),
        .kbd_out_ack  (kbd_out_ack),
        .kbd_tx       (kbd_tx)
    );

endmodule

`default_nettype wire

//--- test/user_io_tb.sv
`default_nettype none

module user_io_tb;

    localparam int NUM_ROWS = 12;
    // one row needs well under 200 SPI cycles
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;
    // first response byte of every transfer
    localparam logic [7:0] CORE_TYPE_BYTE = 8'ha6;

    // one table row with pay[0] as the first payload byte on the wire
    typedef struct packed {
        logic [7:0]      op;
        logic [2:0]      n;
        logic            rnd;
        logic            offer;
        logic [7:0]      exp_stat;
        logic [1:0]      exp_req;
        logic [5:0][7:0] pay;
    } row_t;

    logic                      SPI_CLK      = 1'b0;
    logic                      clk_sys      = 1'b0;
    logic                      SPI_SS_IO    = 1'b1;
    logic                      SPI_MOSI     = 1'b0;
    logic                      SPI_MISO;
    logic                      kbd_in_ack   = 1'b0;
    logic                      kbd_out_req  = 1'b0;
    logic [7:0]                kbd_out_data = 8'h00;
    logic                      kbd_in_req;
    logic [7:0]                kbd_in_data;
    logic                      kbd_out_ack;
    host_if_pkg::host_config_t host_config;
    host_if_pkg::joy_state_t   joy0;
    host_if_pkg::joy_state_t   joy1;

    row_t                      rows [NUM_ROWS];
    logic [31:0]               rng_state  = 32'd40;
    int                        errors     = 0;
    int                        checks     = 0;
    int                        spi_cycles = 0;
    // core model bookkeeping
    int                        offer_cnt    = 0;
    int                        offer_done   = 0;
    logic [7:0]                offer_data   = 8'h00;
    int                        in_req_cnt   = 0;
    int                        out_ack_cnt  = 0;
    logic                      in_req_prev  = 1'b0;
    logic                      out_ack_prev = 1'b0;
    logic [7:0]                in_data_seen = 8'h00;
    // expected core-facing registers
    logic [7:0]                exp_cfg;
    host_if_pkg::joy_state_t   exp_joy [2];
    // one bit per register once written
    logic [2:0]                known = 3'b000;

    // rising edges of clk_sys never meet an SPI_CLK edge
    always #2 SPI_CLK = ~SPI_CLK;
    always #1 clk_sys = ~clk_sys;

    user_io_top u_dut (
        .SPI_CLK      (SPI_CLK),
        .SPI_SS_IO    (SPI_SS_IO),
        .SPI_MOSI     (SPI_MOSI),
        .SPI_MISO     (SPI_MISO),
        .clk_sys      (clk_sys),
        .host_config  (host_config),
        .joy0         (joy0),
        .joy1         (joy1),
        .kbd_in_req   (kbd_in_req),
        .kbd_in_data  (kbd_in_data),
        .kbd_in_ack   (kbd_in_ack),
        .kbd_out_req  (kbd_out_req),
        .kbd_out_data (kbd_out_data),
        .kbd_out_ack  (kbd_out_ack)
    );

    // core model acks kbd_in one cycle after req and offers queued keys
    always @(posedge clk_sys) begin
        kbd_in_ack <= kbd_in_req;
        if (kbd_out_ack) begin
            kbd_out_req <= 1'b0;
        end else if (!kbd_out_req && offer_done != offer_cnt) begin
            kbd_out_req  <= 1'b1;
            kbd_out_data <= offer_data;
            offer_done   <= offer_cnt;
        end
        // count rising edges of both handshakes
        if (kbd_in_req && !in_req_prev) begin
            in_req_cnt   <= in_req_cnt + 1;
            in_data_seen <= kbd_in_data;
        end
        if (kbd_out_ack && !out_ack_prev) begin
            out_ack_cnt <= out_ack_cnt + 1;
        end
        in_req_prev  <= kbd_in_req;
        out_ack_prev <= kbd_out_ack;
    end

    // watchdog
    initial begin : watchdog
        while (spi_cycles < TIMEOUT_CYCLES) begin
            @(posedge SPI_CLK);
            spi_cycles++;
        end
        $display("timeout: run did not finish within %0d SPI cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        rng_state = lcg_step(rng_state);
        b = rng_state[23:16];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // host side of one transfer with the opcode and n payload bytes
    // MOSI changes on a rising edge and MISO is taken on the next one
    task automatic spi_transfer(input logic [7:0] op, input int n,
                                input logic [5:0][7:0] pay, output logic [2:0][7:0] miso);
        logic [7:0] tx;
        logic [7:0] rx;
        int         i;
        int         b;
        miso = '0;
        rx   = 8'h00;
        @(posedge SPI_CLK);
        SPI_SS_IO <= 1'b0;
        for (i = 0; i <= n; i++) begin
            tx = (i == 0) ? op : pay[i - 1];
            for (b = 7; b >= 0; b--) begin
                SPI_MOSI <= tx[b];
                @(posedge SPI_CLK);
                rx = {rx[6:0], SPI_MISO};
            end
            if (i < 3) begin
                miso[i] = rx;
            end
        end
        // end of transfer
        SPI_SS_IO <= 1'b1;
        SPI_MOSI  <= 1'b0;
    endtask

    task automatic run_row(input int r, input row_t row);
        logic [5:0][7:0] pay;
        logic [2:0][7:0] miso;
        logic [7:0]      key;
        logic [7:0]      b;
        int              err0;
        int              req0;
        int              ack0;
        int              sel;
        int              k;
        err0 = errors;
        req0 = in_req_cnt;
        ack0 = out_ack_cnt;
        pay  = row.pay;
        key  = 8'h00;
        if (row.rnd) begin
            for (k = 0; k < 6; k++) begin
                draw_byte(b);
                pay[k] = b;
            end
        end
        // key from the core must be pending before the host reads
        if (row.offer) begin
            draw_byte(key);
            @(posedge SPI_CLK);
            offer_data <= key;
            offer_cnt  <= offer_cnt + 1;
            wait (kbd_out_req === 1'b1);
        end
        spi_transfer(row.op, int'(row.n), pay, miso);
        // settle through the byte sync, decoder and both handshakes
        repeat (16) @(posedge clk_sys);
        @(negedge clk_sys);
        // expected registers from the command rules
        if (row.op == spi_proto_pkg::CMD_CONFIG && row.n != 3'd0) begin
            exp_cfg  = pay[0];
            known[0] = 1'b1;
        end
        if ((row.op == spi_proto_pkg::CMD_JOY0 || row.op == spi_proto_pkg::CMD_JOY1)
                && row.n >= 3'd4) begin
            sel = (row.op == spi_proto_pkg::CMD_JOY1) ? 1 : 0;
            // payload bytes 1 to 4 little endian with bytes 5 and 6 dropped
            for (k = 0; k < 4; k++) begin
                exp_joy[sel][k] = pay[k];
            end
            known[sel + 1] = 1'b1;
        end
        check_value("miso byte 0", 32'(miso[0]), 32'(CORE_TYPE_BYTE));
        if (row.op == spi_proto_pkg::CMD_KBD_READ && row.n != 3'd0) begin
            check_value("miso byte 1", 32'(miso[1]), 32'(row.exp_stat));
        end
        if (row.offer) begin
            check_value("miso byte 2", 32'(miso[2]), 32'(key));
        end
        check_value("kbd_out_ack rises", 32'(out_ack_cnt - ack0), 32'(row.offer));
        check_value("kbd_in_req rises", 32'(in_req_cnt - req0), 32'(row.exp_req));
        if (row.exp_req != 2'd0) begin
            check_value("kbd_in_data", 32'(in_data_seen), 32'(pay[0]));
        end
        // both handshakes closed again
        check_value("kbd_in_req", 32'(kbd_in_req), 32'd0);
        check_value("kbd_out_ack", 32'(kbd_out_ack), 32'd0);
        if (known[0]) begin
            check_value("host_config", 32'(host_config), 32'(exp_cfg));
        end
        if (known[1]) begin
            check_value("joy0", 32'(joy0), 32'(exp_joy[0]));
        end
        if (known[2]) begin
            check_value("joy1", 32'(joy1), 32'(exp_joy[1]));
        end
        $display("row %0d op %02h: %s", r, row.op, (errors == err0) ? "pass" : "FAIL");
    endtask

    initial begin : main
        int r;
        // op, payload count, random payload, key offered, read status, kbd_in reqs, payload
        rows[0]  = '{spi_proto_pkg::CMD_CONFIG, 3'd1, 1'b1, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[1]  = '{spi_proto_pkg::CMD_JOY0, 3'd6, 1'b1, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[2]  = '{spi_proto_pkg::CMD_JOY1, 3'd6, 1'b1, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[3]  = '{spi_proto_pkg::CMD_JOY0, 3'd6, 1'b1, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[4]  = '{spi_proto_pkg::CMD_KBD_WRITE, 3'd1, 1'b1, 1'b0, 8'h00, 2'd1, 48'h0};
        rows[5]  = '{spi_proto_pkg::CMD_KBD_READ, 3'd2, 1'b0, 1'b1, 8'ha1, 2'd0, 48'h0};
        rows[6]  = '{spi_proto_pkg::CMD_KBD_READ, 3'd2, 1'b0, 1'b0, 8'ha0, 2'd0, 48'h0};
        // unlisted opcode and then transfers cut short after the opcode
        rows[7]  = '{8'h33, 3'd4, 1'b1, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[8]  = '{spi_proto_pkg::CMD_CONFIG, 3'd0, 1'b0, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[9]  = '{spi_proto_pkg::CMD_JOY1, 3'd0, 1'b0, 1'b0, 8'h00, 2'd0, 48'h0};
        rows[10] = '{spi_proto_pkg::CMD_CONFIG, 3'd1, 1'b0, 1'b0, 8'h00, 2'd0, 48'hc3};
        rows[11] = '{spi_proto_pkg::CMD_KBD_WRITE, 3'd2, 1'b1, 1'b0, 8'h00, 2'd1, 48'h0};
        // SS high as reset
        repeat (3) @(posedge SPI_CLK);
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r, rows[r]);
        end
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/spi_proto_pkg.sv
source/host_if_pkg.sv
source/spi_frame_shifter.sv
source/spi_byte_sync.sv
source/user_io_decoder.sv
source/user_io_top.sv
test/user_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the user_io testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module user_io_tb -o user_io_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/user_io_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
